// ==== dv/uart_cmd_stim.txt ====
# cmd(hex) reply(hex) mode(0 good,1 bad parity,2 bad stop,3 no reply) exp_data(hex)
# exp_status(0 ok,1 parity,2 framing,3 timeout); reply columns unused for writes
8a5c 00 0 00 0
1300 a7 0 a7 0
2d00 3c 1 3c 1
4100 e1 2 e1 2
5600 00 3 00 3
ff81 00 0 00 0
7f00 ff 0 ff 0
c3ff 00 0 00 0
0255 96 0 96 0

// ==== uart_cmd_top.f ====
+incdir+hdl
hdl/uart_cmd_pkg.sv
hdl/uart_rx_frame.sv
hdl/uart_tx_frame.sv
hdl/uart_cmd_seq.sv
hdl/uart_cmd_top.sv
dv/uart_cmd_clkgen.sv
dv/uart_cmd_checker.sv
dv/uart_cmd_asserts.sv
dv/uart_cmd_tb.sv

// ==== Bender.yml ====
package:
  name: uart_cmd_bridge

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/uart_cmd_pkg.sv
      - hdl/uart_rx_frame.sv
      - hdl/uart_tx_frame.sv
      - hdl/uart_cmd_seq.sv
      - hdl/uart_cmd_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - dv/uart_cmd_clkgen.sv
      - dv/uart_cmd_checker.sv
      - dv/uart_cmd_asserts.sv
      - dv/uart_cmd_tb.sv

// ==== dv/uart_cmd_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_cmd_tb
  import uart_cmd_pkg::*;
();

  localparam int BAUD_DIV  = `UART_BAUD_DIV;
  localparam int REPLY_GAP = 2;     // bit times from request stop bit to reply.

  typedef struct packed {
    uart_cmd_t  cmd;
    logic [7:0] reply;
    logic [1:0] mode;               // 0 good, 1 bad parity, 2 bad stop, 3 silent.
    read_rsp_t  exp;
  } stim_t;

  logic      clk;
  logic      rst_n;
  uart_cmd_t cmd_in;
  logic      cmd_vld;
  logic      cmd_rdy;
  logic      rx;
  logic      tx;
  logic      read_vld;
  read_rsp_t read_rsp;
  logic      exp_vld;
  uart_cmd_t exp_cmd;
  read_rsp_t exp_rsp;
  logic      end_check;
  logic      checked;
  int        mismatch_cnt;
  int        error_cnt;
  stim_t     stim_q[$];
  int        stim_err;
  int        seed;
  int        total;
  int        cycle_cnt   = 0;
  int        cycle_limit = 1000;

  uart_cmd_clkgen u_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  uart_cmd_top u_uart_cmd_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .rx       (rx),
    .tx       (tx),
    .read_vld (read_vld),
    .read_rsp (read_rsp)
  );

  uart_cmd_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_rdy      (cmd_rdy),
    .tx           (tx),
    .read_vld     (read_vld),
    .read_rsp     (read_rsp),
    .exp_vld      (exp_vld),
    .exp_cmd      (exp_cmd),
    .exp_rsp      (exp_rsp),
    .end_check    (end_check),
    .checked      (checked),
    .mismatch_cnt (mismatch_cnt),
    .error_cnt    (error_cnt)
  );

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [15:0] f_cmd;
    logic [7:0]  f_reply;
    int          f_mode;
    logic [7:0]  f_data;
    int          f_status;
    stim_t       s;
    fd = $fopen("dv/uart_cmd_stim.txt", "r");
    if (fd == 0)
    begin
      stim_err++;
      $display("ERROR: cannot open dv/uart_cmd_stim.txt");
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 1 && line[0] != "#")
        begin
          n = $sscanf(line, "%h %h %d %h %d", f_cmd, f_reply, f_mode, f_data, f_status);
          if (n == 5)
          begin
            s.cmd        = f_cmd;
            s.reply      = f_reply;
            s.mode       = f_mode[1:0];
            s.exp.data   = f_data;
            s.exp.status = rsp_status_e'(f_status[1:0]);
            stim_q.push_back(s);
          end
          else
          begin
            stim_err++;
            $display("ERROR: malformed stimulus line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
    if (stim_q.size() == 0)
    begin
      stim_err++;
      $display("ERROR: no commands found in the stimulus file");
    end
  endtask

  // remote device, answers after the request frame has ended.
  task automatic send_reply(input logic [7:0] data, input logic [1:0] mode);
    logic [10:0] bits;
    logic        par;
    par = ^data;
    if (mode == 2'd1)
      par = ~par;
    bits = {(mode == 2'd2) ? 1'b0 : 1'b1, par, data, 1'b0};
    while (tx !== 1'b0)
      @(posedge clk);
    repeat ((`UART_FRAME_BITS + REPLY_GAP) * BAUD_DIV) @(posedge clk);
    for (int i = 0; i < `UART_FRAME_BITS; i++)
    begin
      rx <= bits[i];
      repeat (BAUD_DIV) @(posedge clk);
    end
    rx <= 1'b1;
  endtask

  task automatic run_cmd(input stim_t s);
    int delay;
    delay = $random(seed) & 15;
    repeat (delay) @(posedge clk);
    cmd_in  <= s.cmd;
    cmd_vld <= 1'b1;
    exp_cmd <= s.cmd;
    exp_rsp <= s.exp;
    exp_vld <= 1'b1;
    @(posedge clk);
    exp_vld <= 1'b0;
    while (!cmd_rdy)
      @(posedge clk);   // held until taken.
    cmd_vld <= 1'b0;
    if (!s.cmd.is_write && s.mode != 2'd3)
      send_reply(s.reply, s.mode);
  endtask

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit)
    begin
      $display("ERROR: run timed out after %0d cycles", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial
  begin
    seed      = 32'h63d58f71;
    cmd_in    = '0;
    cmd_vld   = 1'b0;
    rx        = 1'b1;
    exp_vld   = 1'b0;
    exp_cmd   = '0;
    exp_rsp   = '0;
    end_check = 1'b0;
    stim_err  = 0;
    load_stim();
    cycle_limit = stim_q.size() * 40 * BAUD_DIV + 1000;
    wait (rst_n === 1'b1);
    @(posedge clk);
    if (stim_err == 0)
    begin
      foreach (stim_q[i])
        run_cmd(stim_q[i]);
      @(posedge clk);
      while (!cmd_rdy)
        @(posedge clk);
      end_check <= 1'b1;
      while (!checked)
        @(posedge clk);
    end
    total = mismatch_cnt + error_cnt + u_uart_cmd_top.u_asserts.fail_cnt + stim_err;
    $display("errors: %0d mismatch, %0d checker, %0d assertion, %0d stimulus",
             mismatch_cnt, error_cnt, u_uart_cmd_top.u_asserts.fail_cnt, stim_err);
    if (total == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/uart_cmd_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_asserts (
  input wire clk,
  input wire rst_n,
  input wire cmd_rdy,
  input wire tx,
  input wire tx_busy,
  input wire read_vld
);

  int fail_cnt = 0;

  tx_idle_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else
    begin
      fail_cnt++;
      $error("tx is low while cmd_rdy is high");
    end

  read_vld_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
    else
    begin
      fail_cnt++;
      $error("read_vld stayed high for more than one cycle");
    end

  // a write ends one cycle after the framer drops tx_busy.
  rdy_rise_cause: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_rdy) |-> read_vld || ($past(tx_busy, 2) && !tx_busy))
    else
    begin
      fail_cnt++;
      $error("cmd_rdy rose without read_vld or a falling tx_busy");
    end

endmodule

bind uart_cmd_top uart_cmd_asserts u_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .tx_busy  (tx_busy),
  .read_vld (read_vld)
);

`default_nettype wire

// ==== dv/uart_cmd_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_cmd_checker
  import uart_cmd_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire            cmd_rdy,
  input  wire            tx,
  input  wire            read_vld,
  input  wire read_rsp_t read_rsp,
  input  wire            exp_vld,
  input  wire uart_cmd_t exp_cmd,
  input  wire read_rsp_t exp_rsp,
  input  wire            end_check,
  output logic           checked,
  output int             mismatch_cnt,
  output int             error_cnt
);

  localparam int BAUD_DIV = `UART_BAUD_DIV;

  logic [7:0] exp_bytes[$];
  read_rsp_t  exp_reads[$];
  read_rsp_t  exp_read;
  int         frame_mis = 0;
  int         frame_err = 0;
  int         read_mis  = 0;
  int         misc_err  = 0;
  logic       rst_seen  = 1'b0;
  logic       done_q    = 1'b0;

  assign mismatch_cnt = frame_mis + read_mis;
  assign error_cnt    = frame_err + misc_err;
  assign checked      = done_q;

  // decodes tx frames by sampling every bit at its center.
  initial
  begin : tx_decode
    logic       prev;
    logic [7:0] data;
    logic [7:0] exp_byte;
    logic       par;
    logic       stop;
    prev = 1'b1;
    forever
    begin
      @(posedge clk);
      if (rst_n && prev && !tx)
      begin
        repeat (BAUD_DIV / 2) @(posedge clk);
        if (tx !== 1'b0)
        begin
          frame_err++;
          $display("ERROR at %0t: tx start bit did not hold low", $time);
        end
        for (int i = 0; i < 8; i++)
        begin
          repeat (BAUD_DIV) @(posedge clk);
          data[i] = tx;   // lsb first.
        end
        repeat (BAUD_DIV) @(posedge clk);
        par = tx;
        repeat (BAUD_DIV) @(posedge clk);
        stop = tx;
        if (par !== ^data)
        begin
          frame_err++;
          $display("ERROR at %0t: tx frame %02h has wrong even parity", $time, data);
        end
        if (stop !== 1'b1)
        begin
          frame_err++;
          $display("ERROR at %0t: tx frame %02h has a low stop bit", $time, data);
        end
        if (exp_bytes.size() == 0)
        begin
          frame_err++;
          $display("ERROR at %0t: tx frame %02h sent with no byte expected", $time, data);
        end
        else
        begin
          exp_byte = exp_bytes.pop_front();
          if (data !== exp_byte)
          begin
            frame_mis++;
            $display("MISMATCH at %0t: tx byte %02h, expected %02h", $time, data, exp_byte);
          end
        end
      end
      prev = tx;
    end
  end

  always @(posedge clk)
  begin
    rst_seen <= rst_n;
    if (rst_n && !rst_seen && cmd_rdy !== 1'b1)
    begin
      misc_err++;
      $display("ERROR at %0t: cmd_rdy is not high after reset", $time);
    end
    if (exp_vld)
    begin
      exp_bytes.push_back(exp_cmd[15:8]);   // upper byte.
      if (exp_cmd.is_write)
        exp_bytes.push_back(exp_cmd[7:0]);
      else
        exp_reads.push_back(exp_rsp);
    end
    if (rst_n && read_vld)
    begin
      if (exp_reads.size() == 0)
      begin
        misc_err++;
        $display("ERROR at %0t: read_vld with no read pending", $time);
      end
      else
      begin
        exp_read = exp_reads.pop_front();
        if (read_rsp !== exp_read)
        begin
          read_mis++;
          $display("MISMATCH at %0t: read data %02h status %0d, expected data %02h status %0d",
                   $time, read_rsp.data, read_rsp.status, exp_read.data, exp_read.status);
        end
      end
    end
    if (end_check && !done_q)
    begin
      if (exp_bytes.size() != 0)
      begin
        misc_err++;
        $display("ERROR: %0d expected tx frames were never sent", exp_bytes.size());
      end
      if (exp_reads.size() != 0)
      begin
        misc_err++;
        $display("ERROR: %0d expected read results never arrived", exp_reads.size());
      end
      done_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== dv/uart_cmd_clkgen.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_clkgen #(
  parameter int HALF_PERIOD  = 50,
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic rst_n
);

  initial
  begin
    clk   = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

  always #HALF_PERIOD clk = ~clk;   // 100 ns period.

endmodule

`default_nettype wire

// ==== hdl/uart_cmd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_top
  import uart_cmd_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire uart_cmd_t cmd_in,
  input  wire            cmd_vld,
  output logic           cmd_rdy,
  input  wire            rx,
  output logic           tx,
  output logic           read_vld,
  output read_rsp_t      read_rsp
);

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic       frame_vld;
  rx_frame_t  frame;
  logic       rx_active;

  uart_rx_frame u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .frame_vld (frame_vld),
    .frame     (frame),
    .rx_active (rx_active)
  );

  uart_cmd_seq u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .frame_vld (frame_vld),
    .frame     (frame),
    .rx_active (rx_active),
    .read_vld  (read_vld),
    .read_rsp  (read_rsp)
  );

  uart_tx_frame u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

endmodule

`default_nettype wire

// ==== hdl/uart_cmd_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_cmd_seq
  import uart_cmd_pkg::*;
(
  input  wire            clk,
  input  wire            rst_n,
  input  wire uart_cmd_t cmd_in,
  input  wire            cmd_vld,
  output logic           cmd_rdy,
  output logic           tx_start,
  output logic [7:0]     tx_byte,
  input  wire            tx_busy,
  input  wire            frame_vld,
  input  wire rx_frame_t frame,
  input  wire            rx_active,
  output logic           read_vld,
  output read_rsp_t      read_rsp
);

  localparam int GAP_CYCLES = `UART_GAP_CYCLES;
  localparam int TMO_CYCLES = `UART_RSP_TIMEOUT_CYCLES;
  localparam int GAP_W      = $clog2(GAP_CYCLES + 1);
  localparam int TMO_W      = $clog2(TMO_CYCLES + 1);
  localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(GAP_CYCLES - 1);
  localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(TMO_CYCLES - 1);

  seq_state_e       state;
  uart_cmd_t        cmd_q;
  logic [GAP_W-1:0] gap_cnt;
  logic [TMO_W-1:0] tmo_cnt;
  logic             accept;
  logic             frame_done;
  logic             gap_done;
  logic             rsp_frame;
  logic             rsp_tmo;

  assign accept     = cmd_vld && cmd_rdy;
  assign frame_done = !tx_start && !tx_busy;    // framer idle again after our pulse.
  assign gap_done   = (state == SEQ_GAP) && (gap_cnt == GAP_LAST);
  assign rsp_frame  = (state == SEQ_WAIT_RSP) && frame_vld;
  assign rsp_tmo    = (state == SEQ_WAIT_RSP) && !rx_active && (tmo_cnt == TMO_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= SEQ_IDLE;
      cmd_rdy  <= 1'b1;
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      gap_cnt  <= '0;
      tmo_cnt  <= '0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_vld <= 1'b0;
      case (state)
        SEQ_IDLE:
        begin
          if (accept)
          begin
            state    <= SEQ_SEND_HI;
            cmd_rdy  <= 1'b0;
            tx_start <= 1'b1;
          end
        end
        SEQ_SEND_HI:
        begin
          if (frame_done)
          begin
            if (cmd_q.is_write)
            begin
              state   <= SEQ_GAP;
              gap_cnt <= '0;
            end
            else
            begin
              state   <= SEQ_WAIT_RSP;
              tmo_cnt <= '0;
            end
          end
        end
        SEQ_GAP:
        begin
          if (gap_done)
          begin
            state    <= SEQ_SEND_LO;
            tx_start <= 1'b1;
          end
          else
            gap_cnt <= gap_cnt + 1'b1;
        end
        SEQ_SEND_LO:
        begin
          if (frame_done)
          begin
            state   <= SEQ_IDLE;
            cmd_rdy <= 1'b1;
          end
        end
        SEQ_WAIT_RSP:
        begin
          if (rsp_frame || rsp_tmo)
          begin
            state    <= SEQ_IDLE;
            cmd_rdy  <= 1'b1;
            read_vld <= 1'b1;
          end
          else if (!rx_active)
            tmo_cnt <= tmo_cnt + 1'b1;  // paused while a reply is arriving.
        end
        default:
        begin
          state   <= SEQ_IDLE;
          cmd_rdy <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      cmd_q   <= cmd_in;
      tx_byte <= {cmd_in.is_write, cmd_in.addr};   // upper byte goes first.
    end
    else if (gap_done)
      tx_byte <= cmd_q.data;

    if (rsp_frame)
    begin
      read_rsp.data <= frame.data;
      if (frame.stop_err)
        read_rsp.status <= RSP_FRAMING;
      else if (frame.parity_err)
        read_rsp.status <= RSP_PARITY;
      else
        read_rsp.status <= RSP_OK;
    end
    else if (rsp_tmo)
    begin
      read_rsp.data   <= '0;
      read_rsp.status <= RSP_TIMEOUT;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_tx_frame.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_tx_frame (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       tx_start,
  input  wire [7:0] tx_byte,
  output logic      tx_busy,
  output logic      tx
);

  localparam int BAUD_DIV = `UART_BAUD_DIV;
  localparam int CNT_W    = $clog2(BAUD_DIV);
  localparam logic [CNT_W-1:0] BIT_LAST   = CNT_W'(BAUD_DIV - 1);
  localparam logic [3:0]       FRAME_LAST = 4'(`UART_FRAME_BITS - 1);

  logic [10:0]      shreg;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;

  // ones shift in behind the frame, so the line rests high.
  assign tx = shreg[0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      shreg    <= '1;
      tx_busy  <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (tx_start && !tx_busy)
    begin
      shreg    <= {1'b1, ^tx_byte, tx_byte, 1'b0};  // stop, parity, data, start.
      tx_busy  <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (tx_busy)
    begin
      if (baud_cnt == BIT_LAST)
      begin
        baud_cnt <= '0;
        shreg    <= {1'b1, shreg[10:1]};
        if (bit_cnt == FRAME_LAST)
          tx_busy <= 1'b0;          // end of stop bit.
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_rx_frame.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cmd_settings.svh"

module uart_rx_frame
  import uart_cmd_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       rx,
  output logic      frame_vld,
  output rx_frame_t frame,
  output logic      rx_active
);

  localparam int BAUD_DIV = `UART_BAUD_DIV;
  localparam int CNT_W    = $clog2(BAUD_DIV);
  localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(BAUD_DIV - 1);
  localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BAUD_DIV / 2 - 1);
  localparam logic [3:0]       STOP_IDX  = 4'(`UART_FRAME_BITS - 2);

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_BITS
  } rx_state_e;

  rx_state_e        state;
  logic             rx_s1;
  logic             rx_s2;
  logic             rx_prev;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic [8:0]       shreg;      // data then parity.
  logic             bit_tick;

  assign bit_tick = (state == RX_BITS) && (baud_cnt == BIT_LAST);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;        // line idles high.
    end
    else
    begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= RX_IDLE;
      baud_cnt  <= '0;
      bit_cnt   <= '0;
      frame_vld <= 1'b0;
      rx_active <= 1'b0;
    end
    else
    begin
      frame_vld <= 1'b0;
      case (state)
        RX_IDLE:
        begin
          if (rx_prev && !rx_s2)
          begin
            state    <= RX_START;
            baud_cnt <= '0;
          end
        end
        RX_START:
        begin
          if (baud_cnt == HALF_LAST)
          begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (!rx_s2)
            begin
              state     <= RX_BITS;
              rx_active <= 1'b1;
            end
            else
              state <= RX_IDLE;   // glitch, not a start bit.
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        RX_BITS:
        begin
          if (bit_tick)
          begin
            baud_cnt <= '0;
            bit_cnt  <= bit_cnt + 1'b1;
            if (bit_cnt == STOP_IDX)
            begin
              state     <= RX_IDLE;
              frame_vld <= 1'b1;
              rx_active <= 1'b0;
            end
          end
          else
            baud_cnt <= baud_cnt + 1'b1;
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (bit_tick)
    begin
      if (bit_cnt == STOP_IDX)
      begin
        frame.data       <= shreg[7:0];
        frame.parity_err <= ^shreg;   // data plus parity must be even.
        frame.stop_err   <= ~rx_s2;
      end
      else
        shreg <= {rx_s2, shreg[8:1]};  // lsb arrives first.
    end
  end

endmodule

`default_nettype wire

// ==== hdl/uart_cmd_pkg.sv ====
`default_nettype none

package uart_cmd_pkg;

  // host command, bit 15 set means write.
  typedef struct packed {
    logic       is_write;
    logic [6:0] addr;
    logic [7:0] data;
  } uart_cmd_t;

  // one decoded frame from rx.
  typedef struct packed {
    logic [7:0] data;
    logic       parity_err;   // even parity mismatch.
    logic       stop_err;     // stop sample was low.
  } rx_frame_t;

  typedef enum logic [1:0] {
    RSP_OK,
    RSP_PARITY,
    RSP_FRAMING,
    RSP_TIMEOUT
  } rsp_status_e;

  typedef struct packed {
    logic [7:0]  data;
    rsp_status_e status;
  } read_rsp_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_SEND_HI,
    SEQ_GAP,
    SEQ_SEND_LO,
    SEQ_WAIT_RSP
  } seq_state_e;

endpackage

`default_nettype wire

// ==== hdl/uart_cmd_settings.svh ====
`ifndef UART_CMD_SETTINGS_SVH
`define UART_CMD_SETTINGS_SVH

// serial timing, in clock cycles per bit.
`define UART_BAUD_DIV 434

// idle bit times between the upper and lower frame of a write.
`define UART_GAP_BITS 2

// bit times to wait for a reply start bit after the read frame ends.
`define UART_RSP_TIMEOUT_BITS 32

// start, eight data, parity and stop.
`define UART_FRAME_BITS 11

`define UART_GAP_CYCLES (`UART_GAP_BITS * `UART_BAUD_DIV)

`define UART_RSP_TIMEOUT_CYCLES (`UART_RSP_TIMEOUT_BITS * `UART_BAUD_DIV)

`endif
